//--- pfcPkg.sv
`default_nettype none

package pfcPkg;

	localparam int PORT_W = 16;
	localparam int MODE_W = 2;
	localparam int BUS_AW = 28;
	localparam int BUS_DW = 32;
	localparam int LANES  = BUS_DW / 8;
	localparam int OFS_W  = 4;
	localparam int FN_W   = 3 * PORT_W;

	// Register window on the internal bus
	localparam logic [BUS_AW-1:0] REG_BASE = 28'h5FFFFC0;
	localparam logic [BUS_AW-1:0] REG_LAST = 28'h5FFFFEF;

	// Byte offsets of the word registers inside the window
	localparam logic [OFS_W+1:0] OFS_DR  = 6'h00;
	localparam logic [OFS_W+1:0] OFS_IOR = 6'h04;
	localparam logic [OFS_W+1:0] OFS_ACR = 6'h08;
	localparam logic [OFS_W+1:0] OFS_BCR = 6'h0C;

	localparam logic [MODE_W-1:0] MODE_GPIO = 2'd0;
	localparam logic [MODE_W-1:0] MODE_FN1  = 2'd1;
	localparam logic [MODE_W-1:0] MODE_FN2  = 2'd2;
	localparam logic [MODE_W-1:0] MODE_FN3  = 2'd3;

	// Port A pins 4 to 8 have no upper mode bit
	localparam logic [BUS_DW-1:0] PA_CR_WMASK = 32'hFFFD_55FF;
	localparam logic [BUS_DW-1:0] PB_CR_WMASK = 32'hFFFF_FFFF;
	localparam logic [PORT_W-1:0] DR_WMASK    = 16'hFFFF;
	localparam logic [PORT_W-1:0] IOR_WMASK   = 16'hFFFF;

	localparam logic [PORT_W-1:0]        DR_RST  = '0;
	localparam logic [PORT_W-1:0]        IOR_RST = '0;
	localparam logic [MODE_W*PORT_W-1:0] CR_RST  = '0;

	// Ordered fn1, fn2, fn3 from the top
	// fn1 idles high for active-low interrupt inputs
	localparam logic [FN_W-1:0] PA_FN_IDLE = {16'hFFFF, 16'h0000, 16'h0000};
	// Serial receive and clock inputs sit on fn2 of port B
	localparam logic [FN_W-1:0] PB_FN_IDLE = {16'hFFFF, 16'hFFFF, 16'h0000};

	typedef struct packed {
		logic [PORT_W-1:0] dr;
		logic [PORT_W-1:0] ior;
		// Control register 1 (pins 15..8) over control register 2
		logic [PORT_W-1:0][MODE_W-1:0] mode;
	} portCfg_t;

	typedef struct packed {
		logic [PORT_W-1:0] fn1;
		logic [PORT_W-1:0] fn2;
		logic [PORT_W-1:0] fn3;
	} fnVec_t;

	typedef struct packed {
		logic [BUS_AW-1:0] addr;
		logic [BUS_DW-1:0] wdata;
		logic [LANES-1:0]  byteEn;
		logic              we;
		logic              req;
	} busReq_t;

endpackage

`default_nettype wire

//--- pfcRegs.sv
`timescale 1ns/10ps
`default_nettype none

module pfcRegs (
	input  wire logic            CLK,
	input  wire logic            RST_N,
	input  wire logic            CE_R,
	input  wire logic            regSel,
	input  wire pfcPkg::busReq_t bus,
	output pfcPkg::portCfg_t     cfgA,
	output pfcPkg::portCfg_t     cfgB
);

	import pfcPkg::*;

	// Each pair is laid out as seen on the bus, port A or CR1 in the upper half
	logic [BUS_DW-1:0] drPair;
	logic [BUS_DW-1:0] iorPair;
	logic [BUS_DW-1:0] crA;
	logic [BUS_DW-1:0] crB;
	logic [OFS_W+1:0]  wrOfs;
	logic              wrStb;

	function automatic logic [BUS_DW-1:0] mergeLanes(
		input logic [BUS_DW-1:0] cur,
		input logic [BUS_DW-1:0] wdata,
		input logic [LANES-1:0]  byteEn,
		input logic [BUS_DW-1:0] wmask
	);
		logic [BUS_DW-1:0] res;
		res = cur;
		for (int i = 0; i < LANES; i++) begin
			if (byteEn[i]) begin
				res[8*i +: 8] = wdata[8*i +: 8] & wmask[8*i +: 8];
			end
		end
		return res;
	endfunction

	assign wrStb = CE_R & regSel & bus.req & bus.we;
	assign wrOfs = {bus.addr[OFS_W+1:2], 2'b00};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			drPair  <= {DR_RST, DR_RST};
			iorPair <= {IOR_RST, IOR_RST};
			crA     <= CR_RST;
			crB     <= CR_RST;
		end else if (wrStb) begin
			case (wrOfs)
				OFS_DR: begin
					drPair <= mergeLanes(drPair, bus.wdata, bus.byteEn, {DR_WMASK, DR_WMASK});
				end
				OFS_IOR: begin
					iorPair <= mergeLanes(iorPair, bus.wdata, bus.byteEn,
						{IOR_WMASK, IOR_WMASK});
				end
				OFS_ACR: begin
					crA <= mergeLanes(crA, bus.wdata, bus.byteEn, PA_CR_WMASK);
				end
				OFS_BCR: begin
					crB <= mergeLanes(crB, bus.wdata, bus.byteEn, PB_CR_WMASK);
				end
				default: begin
				end
			endcase
		end
	end

	assign cfgA.dr   = drPair[BUS_DW-1 -: PORT_W];
	assign cfgA.ior  = iorPair[BUS_DW-1 -: PORT_W];
	assign cfgA.mode = crA;

	assign cfgB.dr   = drPair[PORT_W-1:0];
	assign cfgB.ior  = iorPair[PORT_W-1:0];
	assign cfgB.mode = crB;

	// Lane enables must be clean whenever the bus master writes
	aWrByteEnKnown: assert property (
		@(posedge CLK) disable iff (!RST_N)
		wrStb |-> !$isunknown(bus.byteEn)
	);

endmodule

`default_nettype wire

//--- pfcPortMux.sv
`timescale 1ns/10ps
`default_nettype none

module pfcPortMux #(
	parameter logic [pfcPkg::FN_W-1:0] FN_IDLE = pfcPkg::PA_FN_IDLE
) (
	input  wire pfcPkg::portCfg_t         cfg,
	input  wire logic [pfcPkg::PORT_W-1:0] pinIn,
	input  wire pfcPkg::fnVec_t           fnOut,
	output logic [pfcPkg::PORT_W-1:0]     pinOut,
	output pfcPkg::fnVec_t                fnIn,
	output logic [pfcPkg::PORT_W-1:0]     gpioRd
);

	import pfcPkg::*;

	localparam fnVec_t IDLE = FN_IDLE;

	logic [PORT_W-1:0] pinGated;

	for (genvar p = 0; p < PORT_W; p++) begin : gPin
		logic [MODE_W-1:0] md;

		assign md = cfg.mode[p];

		always_comb begin
			case (md)
				MODE_FN1: pinOut[p] = fnOut.fn1[p];
				MODE_FN2: pinOut[p] = fnOut.fn2[p];
				MODE_FN3: pinOut[p] = fnOut.fn3[p];
				default:  pinOut[p] = cfg.dr[p];
			endcase
		end

		// A peripheral only sees the pin in its own mode
		assign fnIn.fn1[p] = (md == MODE_FN1) ? pinIn[p] : IDLE.fn1[p];
		assign fnIn.fn2[p] = (md == MODE_FN2) ? pinIn[p] : IDLE.fn2[p];
		assign fnIn.fn3[p] = (md == MODE_FN3) ? pinIn[p] : IDLE.fn3[p];

		assign pinGated[p] = (md == MODE_GPIO) ? pinIn[p] : 1'b0;

		// Output pins read back the latch, inputs the gated pin
		assign gpioRd[p] = cfg.ior[p] ? cfg.dr[p] : pinGated[p];
	end

endmodule

`default_nettype wire

//--- pfcReadback.sv
`timescale 1ns/10ps
`default_nettype none

module pfcReadback (
	input  wire logic                        CLK,
	input  wire logic                        RST_N,
	input  wire logic                        CE_F,
	input  wire logic                        rdStrobe,
	input  wire logic [pfcPkg::OFS_W-1:0]    offset,
	input  wire pfcPkg::portCfg_t            cfgA,
	input  wire pfcPkg::portCfg_t            cfgB,
	input  wire logic [pfcPkg::PORT_W-1:0]   gpioRdA,
	input  wire logic [pfcPkg::PORT_W-1:0]   gpioRdB,
	output logic [pfcPkg::BUS_DW-1:0]        rdata
);

	import pfcPkg::*;

	logic [OFS_W+1:0] rdOfs;

	assign rdOfs = {offset, 2'b00};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdata <= '0;
		end else if (CE_F && rdStrobe) begin
			case (rdOfs)
				OFS_DR:  rdata <= {gpioRdA, gpioRdB};
				OFS_IOR: rdata <= {cfgA.ior, cfgB.ior};
				OFS_ACR: rdata <= cfgA.mode;
				OFS_BCR: rdata <= cfgB.mode;
				// Unused words in the window read as zero
				default: rdata <= '0;
			endcase
		end
	end

	// Read strobe must be clean in every falling phase
	aRdStrobeKnown: assert property (
		@(posedge CLK) disable iff (!RST_N)
		CE_F |-> !$isunknown(rdStrobe)
	);

endmodule

`default_nettype wire

//--- pfcTop.sv
`timescale 1ns/10ps
`default_nettype none

module pfcTop (
	input  wire logic                      CLK,
	input  wire logic                      RST_N,
	input  wire logic                      CE_R,
	input  wire logic                      CE_F,
	input  wire pfcPkg::busReq_t           bus,
	output logic [pfcPkg::BUS_DW-1:0]      rdata,
	output logic                           act,
	input  wire logic [pfcPkg::PORT_W-1:0] paIn,
	output logic [pfcPkg::PORT_W-1:0]      paOut,
	input  wire logic [pfcPkg::PORT_W-1:0] pbIn,
	output logic [pfcPkg::PORT_W-1:0]      pbOut,
	input  wire pfcPkg::fnVec_t            paFnOut,
	output pfcPkg::fnVec_t                 paFnIn,
	input  wire pfcPkg::fnVec_t            pbFnOut,
	output pfcPkg::fnVec_t                 pbFnIn
);

	import pfcPkg::*;

	logic              regSel;
	logic              rdStrobe;
	portCfg_t          cfgA;
	portCfg_t          cfgB;
	logic [PORT_W-1:0] gpioRdA;
	logic [PORT_W-1:0] gpioRdB;

	// Window compare, independent of req
	assign regSel   = (bus.addr >= REG_BASE) && (bus.addr <= REG_LAST);
	assign act      = regSel;
	assign rdStrobe = regSel & bus.req & ~bus.we;

	pfcRegs regs (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.CE_R   (CE_R),
		.regSel (regSel),
		.bus    (bus),
		.cfgA   (cfgA),
		.cfgB   (cfgB)
	);

	pfcPortMux #(.FN_IDLE(PA_FN_IDLE)) portA (
		.cfg    (cfgA),
		.pinIn  (paIn),
		.fnOut  (paFnOut),
		.pinOut (paOut),
		.fnIn   (paFnIn),
		.gpioRd (gpioRdA)
	);

	pfcPortMux #(.FN_IDLE(PB_FN_IDLE)) portB (
		.cfg    (cfgB),
		.pinIn  (pbIn),
		.fnOut  (pbFnOut),
		.pinOut (pbOut),
		.fnIn   (pbFnIn),
		.gpioRd (gpioRdB)
	);

	pfcReadback readback (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE_F     (CE_F),
		.rdStrobe (rdStrobe),
		.offset   (bus.addr[OFS_W+1:2]),
		.cfgA     (cfgA),
		.cfgB     (cfgB),
		.gpioRdA  (gpioRdA),
		.gpioRdB  (gpioRdB),
		.rdata    (rdata)
	);

endmodule

`default_nettype wire

//--- tbPfc.sv
`timescale 1ns/10ps
`default_nettype none

module tbPfc;

	import pfcPkg::*;

	localparam int N_WR    = 64;
	localparam int N_GPIO  = 24;
	localparam int N_ALT   = 48;
	localparam int N_DEC   = 32;
	localparam int N_TESTS = 1 + N_WR + N_GPIO + N_ALT + N_DEC;
	localparam int RST_CYC = 5;
	localparam longint WD_NS = longint'(N_TESTS) * 40 * 8 + RST_CYC * 8;

	logic              CLK;
	logic              RST_N;
	logic              CE_R;
	logic              CE_F;
	busReq_t           bus;
	logic [BUS_DW-1:0] rdata;
	logic              act;
	logic [PORT_W-1:0] paIn;
	logic [PORT_W-1:0] paOut;
	logic [PORT_W-1:0] pbIn;
	logic [PORT_W-1:0] pbOut;
	fnVec_t            paFnOut;
	fnVec_t            paFnIn;
	fnVec_t            pbFnOut;
	fnVec_t            pbFnIn;

	// Reference copy of the register bank, port A in the upper half
	logic [BUS_DW-1:0] mDr;
	logic [BUS_DW-1:0] mIor;
	logic [BUS_DW-1:0] mCrA;
	logic [BUS_DW-1:0] mCrB;
	logic [BUS_DW-1:0] expRd;
	int unsigned       cyc;

	pfcTop DUT (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.CE_R    (CE_R),
		.CE_F    (CE_F),
		.bus     (bus),
		.rdata   (rdata),
		.act     (act),
		.paIn    (paIn),
		.paOut   (paOut),
		.pbIn    (pbIn),
		.pbOut   (pbOut),
		.paFnOut (paFnOut),
		.paFnIn  (paFnIn),
		.pbFnOut (pbFnOut),
		.pbFnIn  (pbFnIn)
	);

	always #4 CLK = ~CLK;

	function automatic logic inWin(input logic [BUS_AW-1:0] addr);
		return (addr >= REG_BASE) && (addr <= REG_LAST);
	endfunction

	function automatic logic [BUS_AW-1:0] regAddr(input logic [5:0] ofs);
		return REG_BASE + BUS_AW'(ofs);
	endfunction

	// Old value with the enabled byte lanes replaced by masked write data
	function automatic logic [BUS_DW-1:0] laneMerge(
		input logic [BUS_DW-1:0] cur,
		input logic [BUS_DW-1:0] wdata,
		input logic [BUS_DW-1:0] mask,
		input logic [LANES-1:0]  be
	);
		logic [BUS_DW-1:0] laneMask;
		laneMask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (cur & ~laneMask) | (wdata & mask & laneMask);
	endfunction

	function automatic logic [PORT_W-1:0] expPinOut(
		input logic [BUS_DW-1:0] cr,
		input logic [PORT_W-1:0] dr,
		input fnVec_t            fo
	);
		logic [PORT_W-1:0] res;
		for (int p = 0; p < PORT_W; p++) begin
			case (cr[2*p +: 2])
				2'd0: res[p] = dr[p];
				2'd1: res[p] = fo.fn1[p];
				2'd2: res[p] = fo.fn2[p];
				default: res[p] = fo.fn3[p];
			endcase
		end
		return res;
	endfunction

	function automatic fnVec_t expFnIn(
		input logic [BUS_DW-1:0] cr,
		input logic [PORT_W-1:0] pin,
		input logic [FN_W-1:0]   idle
	);
		fnVec_t res;
		res = idle;
		for (int p = 0; p < PORT_W; p++) begin
			case (cr[2*p +: 2])
				2'd1: res.fn1[p] = pin[p];
				2'd2: res.fn2[p] = pin[p];
				2'd3: res.fn3[p] = pin[p];
				default: begin
				end
			endcase
		end
		return res;
	endfunction

	function automatic logic [PORT_W-1:0] expGpioRd(
		input logic [BUS_DW-1:0] cr,
		input logic [PORT_W-1:0] dr,
		input logic [PORT_W-1:0] ior,
		input logic [PORT_W-1:0] pin
	);
		logic [PORT_W-1:0] res;
		for (int p = 0; p < PORT_W; p++) begin
			if (ior[p]) begin
				res[p] = dr[p];
			end else begin
				res[p] = (cr[2*p +: 2] == 2'd0) ? pin[p] : 1'b0;
			end
		end
		return res;
	endfunction

	function automatic logic [BUS_DW-1:0] expRead(input logic [BUS_AW-1:0] addr);
		case (addr[5:0] & 6'h3C)
			OFS_DR: return {expGpioRd(mCrA, mDr[31:16], mIor[31:16], paIn),
				expGpioRd(mCrB, mDr[15:0], mIor[15:0], pbIn)};
			OFS_IOR: return mIor;
			OFS_ACR: return mCrA;
			OFS_BCR: return mCrB;
			default: return '0;
		endcase
	endfunction

	task automatic failNow(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// Falling edge, then set the enables for the next rising edge
	task automatic step();
		@(negedge CLK);
		cyc++;
		CE_R = (cyc % 2 == 0);
		CE_F = !CE_R;
	endtask

	task automatic waitPhase(input logic wantCeR);
		step();
		while (CE_R != wantCeR) begin
			step();
		end
	endtask

	task automatic busWrite(
		input logic [BUS_AW-1:0] addr,
		input logic [BUS_DW-1:0] data,
		input logic [LANES-1:0]  be,
		input logic              withCe
	);
		waitPhase(withCe);
		bus.addr   = addr;
		bus.wdata  = data;
		bus.byteEn = be;
		bus.we     = 1'b1;
		bus.req    = 1'b1;
		step();
		bus.req = 1'b0;
		bus.we  = 1'b0;
		if (withCe && inWin(addr)) begin
			case (addr[5:0] & 6'h3C)
				OFS_DR: mDr = laneMerge(mDr, data, {DR_WMASK, DR_WMASK}, be);
				OFS_IOR: mIor = laneMerge(mIor, data, {IOR_WMASK, IOR_WMASK}, be);
				OFS_ACR: mCrA = laneMerge(mCrA, data, PA_CR_WMASK, be);
				OFS_BCR: mCrB = laneMerge(mCrB, data, PB_CR_WMASK, be);
				default: begin
				end
			endcase
		end
	endtask

	task automatic busRead(input logic [BUS_AW-1:0] addr);
		logic [BUS_DW-1:0] exp;
		waitPhase(1'b0);
		bus.addr = addr;
		bus.we   = 1'b0;
		bus.req  = 1'b1;
		exp = expRead(addr);
		step();
		bus.req = 1'b0;
		if (inWin(addr)) begin
			expRd = exp;
		end
	endtask

	task automatic driveRandomPins();
		paIn    = PORT_W'($urandom);
		pbIn    = PORT_W'($urandom);
		paFnOut = FN_W'({$urandom, $urandom});
		pbFnOut = FN_W'({$urandom, $urandom});
	endtask

	aAct: assert property (@(posedge CLK) disable iff (!RST_N) act == inWin(bus.addr))
		else failNow($sformatf("act %b for address %h", $sampled(act), $sampled(bus.addr)));

	aRdata: assert property (@(posedge CLK) disable iff (!RST_N) rdata == expRd)
		else failNow($sformatf("rdata %h, expected %h", $sampled(rdata), $sampled(expRd)));

	aPaOut: assert property (@(posedge CLK) disable iff (!RST_N)
		paOut == expPinOut(mCrA, mDr[31:16], paFnOut))
		else failNow($sformatf("paOut %h is wrong", $sampled(paOut)));

	aPbOut: assert property (@(posedge CLK) disable iff (!RST_N)
		pbOut == expPinOut(mCrB, mDr[15:0], pbFnOut))
		else failNow($sformatf("pbOut %h is wrong", $sampled(pbOut)));

	aPaFnIn: assert property (@(posedge CLK) disable iff (!RST_N)
		paFnIn == expFnIn(mCrA, paIn, PA_FN_IDLE))
		else failNow($sformatf("paFnIn %h is wrong", $sampled(paFnIn)));

	aPbFnIn: assert property (@(posedge CLK) disable iff (!RST_N)
		pbFnIn == expFnIn(mCrB, pbIn, PB_FN_IDLE))
		else failNow($sformatf("pbFnIn %h is wrong", $sampled(pbFnIn)));

	initial begin
		#(WD_NS);
		$display("Timeout: tests did not finish within %0d ns", WD_NS);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [BUS_AW-1:0] a;
		logic [BUS_DW-1:0] d;
		logic [LANES-1:0]  be;
		void'($urandom(32'h47841682));
		CLK     = 1'b0;
		RST_N   = 1'b0;
		CE_R    = 1'b1;
		CE_F    = 1'b0;
		bus     = '0;
		paIn    = '0;
		pbIn    = '0;
		paFnOut = '0;
		pbFnOut = '0;
		mDr     = '0;
		mIor    = '0;
		mCrA    = '0;
		mCrB    = '0;
		expRd   = '0;
		cyc     = 0;
		repeat (RST_CYC) step();
		RST_N = 1'b1;

		// Reset state with quiet pins
		for (int o = 0; o < 4; o++) begin
			busRead(regAddr(6'(4 * o)));
		end

		for (int i = 0; i < N_WR; i++) begin
			driveRandomPins();
			a  = regAddr(6'(4 * ($urandom % 4)));
			d  = $urandom;
			be = LANES'($urandom);
			busWrite(a, d, be, 1'b1);
			busRead(a);
			if (i % 4 == 3) begin
				busWrite(a, ~d, 4'hF, 1'b0);
				busRead(a);
			end
		end
		busWrite(regAddr(OFS_ACR), 32'hFFFF_FFFF, 4'hF, 1'b1);
		busRead(regAddr(OFS_ACR));

		// General I/O with every pin in mode 0
		busWrite(regAddr(OFS_ACR), '0, 4'hF, 1'b1);
		busWrite(regAddr(OFS_BCR), '0, 4'hF, 1'b1);
		for (int i = 0; i < N_GPIO; i++) begin
			busWrite(regAddr(OFS_DR), $urandom, 4'hF, 1'b1);
			busWrite(regAddr(OFS_IOR), $urandom, 4'hF, 1'b1);
			driveRandomPins();
			busRead(regAddr(OFS_DR));
		end

		for (int i = 0; i < N_ALT; i++) begin
			busWrite(regAddr(OFS_ACR), $urandom, 4'hF, 1'b1);
			busWrite(regAddr(OFS_BCR), $urandom, 4'hF, 1'b1);
			busWrite(regAddr(OFS_DR), $urandom, 4'hF, 1'b1);
			busWrite(regAddr(OFS_IOR), $urandom, LANES'($urandom), 1'b1);
			driveRandomPins();
			step();
			busRead(regAddr(OFS_DR));
		end

		busRead(regAddr(6'h10));
		for (int i = 0; i < N_DEC; i++) begin
			case ($urandom % 6)
				0: a = REG_BASE - 1 - BUS_AW'($urandom % 64);
				1: a = REG_LAST + 1 + BUS_AW'($urandom % 64);
				2: a = REG_BASE + BUS_AW'($urandom % 48);
				3: a = BUS_AW'($urandom);
				4: a = regAddr(6'h10);
				default: a = REG_LAST;
			endcase
			bus.addr = a;
			step();
			busWrite(a, $urandom, LANES'($urandom), 1'b1);
			busRead(a);
			driveRandomPins();
			busRead(regAddr(6'(4 * ($urandom % 4))));
		end

		step();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
pfcPkg.sv
pfcRegs.sv
pfcPortMux.sv
pfcReadback.sv
pfcTop.sv
tbPfc.sv

//--- Makefile
TOP := tbPfc
OBJ := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): sim.f $(shell cat sim.f)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -Mdir $(OBJ) -f sim.f

run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
